/* build.f */
design/itemMapPkg.sv
design/randomSource.sv
design/placementControl.sv
design/itemPlacer.sv
design/itemTable.sv
design/itemMapTop.sv
dv/clockGen.sv
dv/itemMapTb.sv

/* design/itemMapPkg.sv */
// shared sizes and structs for the item map; limits assume MAX_ITEMS stays below 2**INDEX_BITS
package itemMapPkg;

    // table and request sizing
    localparam int MAX_ITEMS     = 30;
    localparam int INDEX_BITS    = 5;
    localparam int QUANTITY_BITS = 6;

    // playfield grid where one cell is 16 px in 1/16 px units
    localparam int GRID_COLS  = 20;
    localparam int GRID_ROWS  = 10;
    localparam int CELL_SCALE = 256;
    localparam int COL_BITS   = 5;  // raw column bits before reduction
    localparam int ROW_BITS   = 4;

    // entry field widths
    localparam int X_BITS     = 13;
    localparam int Y_BITS     = 12;
    localparam int SPARE_BITS = 5;
    localparam int DELTA_BITS = 11;

    // random source
    localparam int LFSR_BITS = 16;
    localparam logic [LFSR_BITS-1:0] LFSR_SEED = 16'hACE1;
    localparam logic [LFSR_BITS-1:0] LFSR_TAPS = 16'hB400;  // x^16 + x^14 + x^13 + x^11 + 1

    typedef logic [INDEX_BITS-1:0] itemIndex;
    typedef logic [X_BITS-1:0] xCoord;
    typedef logic [Y_BITS-1:0] yCoord;
    typedef logic [COL_BITS-1:0] colIndex;
    typedef logic [ROW_BITS-1:0] rowIndex;
    typedef logic [LFSR_BITS-1:0] lfsrWord;

    // one 32-bit table entry with x in the top bits
    typedef struct packed {
        xCoord                 xPos;
        yCoord                 yPos;
        logic [SPARE_BITS-1:0] spare;    // kept zero
        logic                  visible;
        logic                  moved;
    } itemEntry;

    // one mover request with two's complement deltas
    typedef struct packed {
        logic                         enable;
        itemIndex                     index;
        logic signed [DELTA_BITS-1:0] deltaX;
        logic signed [DELTA_BITS-1:0] deltaY;
        logic                         moved;
        logic                         visible;
    } moveCmd;

endpackage

/* design/itemMapTop.sv */
// item map top; start and move ports are plain strobes with no handshake, moves while busy are lost
`timescale 1ns/1ns

module itemMapTop (
    input  logic                                 clock,
    input  logic                                 resetn,
    input  logic                                 start,
    input  logic [itemMapPkg::QUANTITY_BITS-1:0] quantity,
    input  itemMapPkg::moveCmd                   moveA,
    input  itemMapPkg::moveCmd                   moveB,
    input  itemMapPkg::itemIndex                 readIndex,
    output itemMapPkg::itemEntry                 readEntry,
    output itemMapPkg::itemIndex                 itemCount,
    output logic                                 busy,
    output logic                                 done
);

    logic                 placeRequest;
    logic                 placeDone;
    logic                 clearTable;
    logic                 writeEn;
    itemMapPkg::itemIndex writeIndex;
    itemMapPkg::itemEntry writeEntry;
    itemMapPkg::itemIndex scanIndex;
    itemMapPkg::itemEntry scanEntry;
    itemMapPkg::lfsrWord  randomValue;

    placementControl control0 (
        .clock        (clock),
        .resetn       (resetn),
        .start        (start),
        .quantity     (quantity),
        .placeDone    (placeDone),
        .placeRequest (placeRequest),
        .placedCount  (itemCount),    // placed count is the live item count
        .busy         (busy),
        .done         (done),
        .clearTable   (clearTable)
    );

    itemPlacer placer0 (
        .clock        (clock),
        .resetn       (resetn),
        .placeRequest (placeRequest),
        .placedCount  (itemCount),
        .randomValue  (randomValue),
        .scanEntry    (scanEntry),
        .scanIndex    (scanIndex),
        .writeEn      (writeEn),
        .writeIndex   (writeIndex),
        .writeEntry   (writeEntry),
        .placeDone    (placeDone)
    );

    randomSource random0 (
        .clock  (clock),
        .resetn (resetn),
        .value  (randomValue)
    );

    itemTable table0 (
        .clock      (clock),
        .resetn     (resetn),
        .clearTable (clearTable),
        .writeEn    (writeEn),
        .writeIndex (writeIndex),
        .writeEntry (writeEntry),
        .moveA      (moveA),
        .moveB      (moveB),
        .busy       (busy),
        .itemCount  (itemCount),
        .scanIndex  (scanIndex),
        .readIndex  (readIndex),
        .scanEntry  (scanEntry),
        .readEntry  (readEntry)
    );

endmodule

/* design/itemPlacer.sv */
// draws random grid cells and rejects any cell already used; placedCount must hold during a placement
`timescale 1ns/1ns

module itemPlacer (
    input  logic                 clock,
    input  logic                 resetn,
    input  logic                 placeRequest,
    input  itemMapPkg::itemIndex placedCount,
    input  itemMapPkg::lfsrWord  randomValue,
    input  itemMapPkg::itemEntry scanEntry,
    output itemMapPkg::itemIndex scanIndex,
    output logic                 writeEn,
    output itemMapPkg::itemIndex writeIndex,
    output itemMapPkg::itemEntry writeEntry,
    output logic                 placeDone
);

    typedef enum logic [2:0] {
        stateIdle,
        stateDraw,
        stateScanIssue,
        stateScanCompare,
        stateWrite
    } placerState;

    placerState           state;
    itemMapPkg::itemEntry candidate;
    itemMapPkg::itemEntry newCandidate;
    itemMapPkg::itemIndex scanPtr;
    itemMapPkg::itemIndex nextPtr;
    itemMapPkg::colIndex  columnRaw;
    itemMapPkg::colIndex  column;
    itemMapPkg::rowIndex  rowRaw;
    itemMapPkg::rowIndex  row;
    logic                 hit;
    logic                 lastEntry;

    // top bits give the column and bottom bits the row
    assign columnRaw = randomValue[itemMapPkg::LFSR_BITS-1 -: itemMapPkg::COL_BITS];
    assign rowRaw    = randomValue[itemMapPkg::ROW_BITS-1:0];

    // raw range is under twice the grid size so one subtraction is enough
    assign column = (columnRaw >= itemMapPkg::GRID_COLS) ?
                    columnRaw - itemMapPkg::colIndex'(itemMapPkg::GRID_COLS) : columnRaw;
    assign row    = (rowRaw >= itemMapPkg::GRID_ROWS) ?
                    rowRaw - itemMapPkg::rowIndex'(itemMapPkg::GRID_ROWS) : rowRaw;

    always_comb begin
        newCandidate         = '0;
        newCandidate.xPos    = itemMapPkg::xCoord'(column) *
                               itemMapPkg::xCoord'(itemMapPkg::CELL_SCALE);
        newCandidate.yPos    = itemMapPkg::yCoord'(row) *
                               itemMapPkg::yCoord'(itemMapPkg::CELL_SCALE);
        newCandidate.visible = 1'b1;
        newCandidate.moved   = 1'b0;
    end

    // only the position decides a collision
    assign hit = (scanEntry.xPos == candidate.xPos) && (scanEntry.yPos == candidate.yPos);

    assign nextPtr   = scanPtr + 1'b1;
    assign lastEntry = (nextPtr == placedCount);

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state   <= stateIdle;
            scanPtr <= '0;
        end else begin
            case (state)
                stateIdle: begin
                    if (placeRequest) begin
                        state <= stateDraw;
                    end
                end
                stateDraw: begin
                    scanPtr <= '0;
                    // first item has nothing to compare against
                    state   <= (placedCount == '0) ? stateWrite : stateScanIssue;
                end
                stateScanIssue: begin
                    state <= stateScanCompare;  // table returns the entry next cycle
                end
                stateScanCompare: begin
                    if (hit) begin
                        state <= stateDraw;     // cell taken so try another
                    end else if (lastEntry) begin
                        state <= stateWrite;
                    end else begin
                        scanPtr <= nextPtr;
                        state   <= stateScanIssue;
                    end
                end
                stateWrite: begin
                    state <= stateIdle;
                end
                default: begin
                    state <= stateIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == stateDraw) begin
            candidate <= newCandidate;
        end
    end

    assign scanIndex  = scanPtr;
    assign writeEn    = (state == stateWrite);
    assign writeIndex = placedCount;        // next free slot
    assign writeEntry = candidate;
    assign placeDone  = (state == stateWrite);

endmodule

/* design/itemTable.sv */
// item storage; moves apply only while idle, and reads past MAX_ITEMS return a zero entry
`timescale 1ns/1ns

module itemTable (
    input  logic                 clock,
    input  logic                 resetn,
    input  logic                 clearTable,
    input  logic                 writeEn,
    input  itemMapPkg::itemIndex writeIndex,
    input  itemMapPkg::itemEntry writeEntry,
    input  itemMapPkg::moveCmd   moveA,
    input  itemMapPkg::moveCmd   moveB,
    input  logic                 busy,
    input  itemMapPkg::itemIndex itemCount,
    input  itemMapPkg::itemIndex scanIndex,
    input  itemMapPkg::itemIndex readIndex,
    output itemMapPkg::itemEntry scanEntry,
    output itemMapPkg::itemEntry readEntry
);

    itemMapPkg::itemEntry entries [itemMapPkg::MAX_ITEMS];
    logic                 moveAValid;
    logic                 moveBValid;

    // adds the signed deltas, wraps at field width, replaces both flags
    function automatic itemMapPkg::itemEntry applyMove(
        input itemMapPkg::itemEntry current,
        input itemMapPkg::moveCmd   cmd
    );
        itemMapPkg::itemEntry result;
        result         = current;
        result.xPos    = current.xPos + itemMapPkg::xCoord'(cmd.deltaX);
        result.yPos    = current.yPos + itemMapPkg::yCoord'(cmd.deltaY);
        result.moved   = cmd.moved;
        result.visible = cmd.visible;
        return result;
    endfunction

    function automatic itemMapPkg::itemEntry readAt(input itemMapPkg::itemIndex index);
        itemMapPkg::itemEntry result;
        result = '0;
        if (index < itemMapPkg::MAX_ITEMS) begin
            result = entries[index];
        end
        return result;
    endfunction

    // entries at or past the count are not live items
    assign moveAValid = moveA.enable && (moveA.index < itemCount);
    // moveA wins when both address the same entry
    assign moveBValid = moveB.enable && (moveB.index < itemCount) &&
                        !(moveAValid && (moveA.index == moveB.index));

    always_ff @(posedge clock) begin
        if (!resetn) begin
            for (int i = 0; i < itemMapPkg::MAX_ITEMS; i++) begin
                entries[i] <= '0;
            end
        end else if (writeEn) begin
            entries[writeIndex] <= writeEntry;
        end else if (clearTable) begin
            for (int i = 0; i < itemMapPkg::MAX_ITEMS; i++) begin
                entries[i] <= '0;
            end
        end else if (!busy) begin
            if (moveAValid) begin
                entries[moveA.index] <= applyMove(entries[moveA.index], moveA);
            end
            if (moveBValid) begin
                entries[moveB.index] <= applyMove(entries[moveB.index], moveB);
            end
        end
    end

    // scan port for the placer, display port for the drawing engine
    always_ff @(posedge clock) begin
        scanEntry <= readAt(scanIndex);
        readEntry <= readAt(readIndex);
    end

endmodule

/* design/placementControl.sv */
// generation control; quantity is clamped to MAX_ITEMS and a start while busy is dropped
`timescale 1ns/1ns

module placementControl (
    input  logic                                 clock,
    input  logic                                 resetn,
    input  logic                                 start,
    input  logic [itemMapPkg::QUANTITY_BITS-1:0] quantity,
    input  logic                                 placeDone,
    output logic                                 placeRequest,
    output itemMapPkg::itemIndex                 placedCount,
    output logic                                 busy,
    output logic                                 done,
    output logic                                 clearTable
);

    itemMapPkg::itemIndex quantityReg;
    itemMapPkg::itemIndex clampedQuantity;
    itemMapPkg::itemIndex nextCount;
    itemMapPkg::itemIndex compareCount;
    logic                 reached;

    assign clampedQuantity = (quantity > itemMapPkg::MAX_ITEMS) ?
                             itemMapPkg::itemIndex'(itemMapPkg::MAX_ITEMS) :
                             itemMapPkg::itemIndex'(quantity);
    assign nextCount = placedCount + 1'b1;

    // count as it will be after this edge, zero right after the clear
    assign compareCount = placeDone ? nextCount : placedCount;
    assign reached      = (compareCount == quantityReg);

    always_ff @(posedge clock) begin
        if (!resetn) begin
            quantityReg  <= '0;
            placedCount  <= '0;
            busy         <= 1'b0;
            done         <= 1'b0;
            clearTable   <= 1'b0;
            placeRequest <= 1'b0;
        end else if (start && !busy) begin
            quantityReg  <= clampedQuantity;
            placedCount  <= '0;
            busy         <= 1'b1;
            done         <= 1'b0;
            clearTable   <= 1'b1;   // table wiped while busy rises
            placeRequest <= 1'b0;
        end else begin
            clearTable   <= 1'b0;
            done         <= 1'b0;
            placeRequest <= 1'b0;
            if (placeDone) begin
                placedCount <= nextCount;
            end
            if (clearTable || placeDone) begin
                if (reached) begin
                    done <= 1'b1;
                    busy <= 1'b0;
                end else begin
                    placeRequest <= 1'b1;  // ask for the next item
                end
            end
        end
    end

endmodule

/* design/randomSource.sv */
// free-running Galois LFSR, steps every cycle out of reset; the sequence is not meant to be secure
`timescale 1ns/1ns

module randomSource (
    input  logic                clock,
    input  logic                resetn,
    output itemMapPkg::lfsrWord value
);

    logic feedback;

    assign feedback = value[0];  // bit shifted out decides the tap xor

    // seed is nonzero so the register never locks up at all zeros
    always_ff @(posedge clock) begin
        if (!resetn) begin
            value <= itemMapPkg::LFSR_SEED;
        end else if (feedback) begin
            value <= (value >> 1) ^ itemMapPkg::LFSR_TAPS;
        end else begin
            value <= value >> 1;
        end
    end

endmodule

/* dv/clockGen.sv */
// testbench clock of 40 ns period; reset held low for 16 cycles and released just after an edge
`timescale 1ns/1ns

module clockGen (
    output logic clock,
    output logic resetn
);

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 16;

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #2 resetn = 1'b1;  // same skew as the other inputs
    end

endmodule

/* dv/itemMapTb.sv */
// testbench for itemMapTop; checks placement rules and cell uniqueness, not the exact LFSR cells
`timescale 1ns/1ns

module itemMapTb;

    localparam int CLOCK_PERIOD     = 40;
    localparam int DRIVE_DELAY      = 2;
    localparam int NUM_GENERATIONS  = 10;
    localparam int MOVES_PER_GEN    = 10;
    localparam int SCAN_ALLOWANCE   = 60;    // cycles per item with redraws
    localparam int MOVE_ALLOWANCE   = 7000;  // all move phases and read sweeps
    localparam int GENERATION_LIMIT = 2 * itemMapPkg::MAX_ITEMS * SCAN_ALLOWANCE;
    localparam int WATCHDOG_NS      = 2 * CLOCK_PERIOD *
        (NUM_GENERATIONS * itemMapPkg::MAX_ITEMS * SCAN_ALLOWANCE + MOVE_ALLOWANCE);
    localparam int INDEX_RANGE      = 2 ** itemMapPkg::INDEX_BITS;

    logic                                 clock;
    logic                                 resetn;
    logic                                 start;
    logic [itemMapPkg::QUANTITY_BITS-1:0] quantity;
    itemMapPkg::moveCmd                   moveA;
    itemMapPkg::moveCmd                   moveB;
    itemMapPkg::itemIndex                 readIndex;
    itemMapPkg::itemEntry                 readEntry;
    itemMapPkg::itemIndex                 itemCount;
    logic                                 busy;
    logic                                 done;

    itemMapPkg::itemEntry refTable [itemMapPkg::MAX_ITEMS];  // mirror of the DUT table
    int                   expectedCount = 0;
    int                   doneCount     = 0;
    int                   checkErrors   = 0;
    int                   otherErrors   = 0;
    logic                 expectValid   = 1'b0;
    itemMapPkg::itemEntry expectEntry   = '0;
    logic                 checkValid    = 1'b0;
    itemMapPkg::itemEntry checkEntry    = '0;
    itemMapPkg::itemIndex checkIndex    = '0;

    clockGen clockGen0 (.clock(clock), .resetn(resetn));

    itemMapTop dut0 (
        .clock     (clock),
        .resetn    (resetn),
        .start     (start),
        .quantity  (quantity),
        .moveA     (moveA),
        .moveB     (moveB),
        .readIndex (readIndex),
        .readEntry (readEntry),
        .itemCount (itemCount),
        .busy      (busy),
        .done      (done)
    );

    task automatic reportMismatch(input string message);
        checkErrors++;
        $display("CHECK FAILED at %0t ns: %s", $time, message);
    endtask

    // readEntry follows readIndex by one edge, so the expectation is delayed to match
    always @(posedge clock) begin
        checkValid <= expectValid;
        checkEntry <= expectEntry;
        checkIndex <= readIndex;
        if (done) begin
            doneCount <= doneCount + 1;
        end
    end

    readCheck: assert property (@(posedge clock) checkValid |-> readEntry == checkEntry)
        else reportMismatch($sformatf("entry %0d read %h, expected %h", $sampled(checkIndex),
                                      $sampled(readEntry), $sampled(checkEntry)));
    donePulseCheck: assert property (@(posedge clock) disable iff (!resetn) done |=> !done)
        else reportMismatch("done held high for more than one cycle");
    doneStateCheck: assert property (@(posedge clock) disable iff (!resetn)
                                     done |-> !busy && itemCount == expectedCount)
        else reportMismatch($sformatf("done with busy %b and itemCount %0d, expected %0d",
                                      $sampled(busy), $sampled(itemCount), expectedCount));
    busyEndCheck: assert property (@(posedge clock) disable iff (!resetn) $fell(busy) |-> done)
        else reportMismatch("busy fell without a done pulse");
    emptyDoneCheck: assert property (@(posedge clock) disable iff (!resetn)
                                     $rose(busy) && expectedCount == 0 |=> done)
        else reportMismatch("zero quantity did not give done one cycle after busy");

    task automatic nextCycle();
        @(posedge clock);
        #DRIVE_DELAY;
    endtask

    function automatic int wrapAdd(input int value, input int delta, input int width);
        int span;
        span = 1 << width;
        return ((value + delta) % span + span) % span;
    endfunction

    function automatic itemMapPkg::itemEntry expectedAfterMove(input itemMapPkg::itemEntry entry,
                                                               input itemMapPkg::moveCmd cmd);
        itemMapPkg::itemEntry result;
        result         = entry;
        result.xPos    = itemMapPkg::xCoord'(wrapAdd(int'(entry.xPos), int'(cmd.deltaX),
                                                     itemMapPkg::X_BITS));
        result.yPos    = itemMapPkg::yCoord'(wrapAdd(int'(entry.yPos), int'(cmd.deltaY),
                                                     itemMapPkg::Y_BITS));
        result.moved   = cmd.moved;
        result.visible = cmd.visible;
        return result;
    endfunction

    function automatic itemMapPkg::moveCmd randomMove(input int index);
        itemMapPkg::moveCmd cmd;
        logic [31:0]        bits;
        bits        = $urandom;
        cmd.enable  = 1'b1;
        cmd.index   = itemMapPkg::itemIndex'(index);
        cmd.deltaX  = bits[itemMapPkg::DELTA_BITS-1:0];
        cmd.deltaY  = bits[2*itemMapPkg::DELTA_BITS-1:itemMapPkg::DELTA_BITS];
        cmd.moved   = bits[2*itemMapPkg::DELTA_BITS];
        cmd.visible = bits[2*itemMapPkg::DELTA_BITS+1];
        return cmd;
    endfunction

    function automatic int pickDead();
        return expectedCount + int'($urandom % (INDEX_RANGE - expectedCount));
    endfunction

    function automatic int pickLive();
        if (expectedCount == 0) begin
            return pickDead();  // with nothing live any index is out of range
        end
        return int'($urandom % expectedCount);
    endfunction

    task automatic verifyTable();
        for (int i = 0; i < itemMapPkg::MAX_ITEMS; i++) begin
            readIndex   = itemMapPkg::itemIndex'(i);
            expectEntry = refTable[i];
            expectValid = 1'b1;
            nextCycle();
        end
        expectValid = 1'b0;
        repeat (2) nextCycle();  // let the last two reads reach the check
    endtask

    // reads the fresh table back, checks the placement rules and takes it as reference
    task automatic loadTable();
        itemMapPkg::itemEntry entry;
        for (int i = 0; i < itemMapPkg::MAX_ITEMS; i++) begin
            readIndex = itemMapPkg::itemIndex'(i);
            nextCycle();
            entry       = readEntry;
            refTable[i] = '0;
            if (i >= expectedCount) begin
                assert (entry == '0)
                    else reportMismatch($sformatf("entry %0d above count reads %h", i, entry));
            end else begin
                assert (entry.visible && !entry.moved && entry.spare == '0)
                    else reportMismatch($sformatf("entry %0d has bad flags %h", i, entry));
                assert (entry.xPos % itemMapPkg::CELL_SCALE == 0 &&
                        entry.yPos % itemMapPkg::CELL_SCALE == 0 &&
                        entry.xPos / itemMapPkg::CELL_SCALE < itemMapPkg::GRID_COLS &&
                        entry.yPos / itemMapPkg::CELL_SCALE < itemMapPkg::GRID_ROWS)
                    else reportMismatch($sformatf("entry %0d off the grid %h", i, entry));
                for (int j = 0; j < i; j++) begin
                    assert (entry.xPos != refTable[j].xPos || entry.yPos != refTable[j].yPos)
                        else reportMismatch($sformatf("entries %0d and %0d share a cell", j, i));
                end
                refTable[i] = entry;
            end
        end
    endtask

    task automatic runGeneration(input int request);
        int startDones;
        int cycles;
        expectedCount = (request > itemMapPkg::MAX_ITEMS) ? itemMapPkg::MAX_ITEMS : request;
        startDones    = doneCount;
        quantity      = request[itemMapPkg::QUANTITY_BITS-1:0];
        start         = 1'b1;
        nextCycle();
        start    = 1'b0;
        quantity = '0;  // a restart would latch an empty request
        cycles   = 0;
        // the stray start with its new quantity and the moves while busy must all be dropped
        while (!done && cycles < GENERATION_LIMIT) begin
            start = (cycles == 3) && busy;
            moveA = randomMove(pickLive());
            moveB = randomMove(int'($urandom % INDEX_RANGE));
            nextCycle();
            cycles++;
        end
        start = 1'b0;
        moveA = '0;
        moveB = '0;
        if (!done) begin
            otherErrors++;
            $display("generation for quantity %0d did not finish within %0d cycles",
                     request, GENERATION_LIMIT);
        end
        repeat (2) nextCycle();
        assert (doneCount - startDones == 1)
            else reportMismatch($sformatf("saw %0d done pulses", doneCount - startDones));
        assert (itemCount == expectedCount && !busy)
            else reportMismatch($sformatf("itemCount %0d, expected %0d", itemCount, expectedCount));
        loadTable();
    endtask

    task automatic movePhase();
        int   indexA;
        int   indexB;
        logic applyA;
        logic applyB;
        for (int n = 0; n < MOVES_PER_GEN; n++) begin
            indexA = pickLive();
            indexB = (expectedCount > 0) ? (indexA + 1) % expectedCount : pickDead();
            moveA  = '0;
            moveB  = '0;
            case (n % 5)
                0: moveA = randomMove(indexA);
                1: moveB = randomMove(indexA);
                2: begin
                    moveA = randomMove(indexA);
                    moveB = randomMove(indexB);
                end
                3: begin
                    moveA = randomMove(indexA);  // moveA wins on the same entry
                    moveB = randomMove(indexA);
                end
                default: begin
                    moveA = randomMove(pickDead());
                    moveB = randomMove(pickDead());
                end
            endcase
            applyA = moveA.enable && moveA.index < expectedCount;
            applyB = moveB.enable && moveB.index < expectedCount &&
                     !(applyA && moveB.index == moveA.index);
            if (applyA) begin
                refTable[moveA.index] = expectedAfterMove(refTable[moveA.index], moveA);
            end
            if (applyB) begin
                refTable[moveB.index] = expectedAfterMove(refTable[moveB.index], moveB);
            end
            nextCycle();
            moveA = '0;
            moveB = '0;
            verifyTable();
        end
    endtask

    initial begin
        int request;
        void'($urandom(86));
        start     = 1'b0;
        quantity  = '0;
        moveA     = '0;
        moveB     = '0;
        readIndex = '0;
        for (int i = 0; i < itemMapPkg::MAX_ITEMS; i++) begin
            refTable[i] = '0;
        end
        @(posedge resetn);
        nextCycle();
        assert (!busy && !done && itemCount == 0)
            else reportMismatch("outputs not idle after reset");
        verifyTable();
        for (int g = 0; g < NUM_GENERATIONS; g++) begin
            if (g == 0) begin
                request = 45;  // above the table depth
            end else if (g == 2) begin
                request = 0;
            end else begin
                request = int'($urandom % (itemMapPkg::MAX_ITEMS + 1));
            end
            runGeneration(request);
            movePhase();
        end
        $display("errors: %0d failed checks, %0d other failures", checkErrors, otherErrors);
        if (checkErrors == 0 && otherErrors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

endmodule
